// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_keccak_miner -f flist.f
	@out="$$(./obj_dir/Vtb_keccak_miner +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// File: flist.f
+incdir+tests
hdl/keccak_pkg.sv
hdl/keccak_absorb.sv
hdl/keccak_round.sv
hdl/keccak_last_round.sv
hdl/keccak_pipeline.sv
hdl/keccak_miner.sv
tests/keccak_miner_props.sv
tests/tb_keccak_miner.sv

// File: hdl/keccak_absorb.sv
`timescale 1ns/1ps

module keccak_absorb
  import keccak_pkg::*;
(
  input  job_t   job,
  output state_t state
);

  localparam int lane_bytes = lane_w / 8;
  localparam int rate_lanes = rate_w / lane_w;  // 17

  logic [rate_w-1:0] block;     // header, nonce, padding
  logic [rate_w-1:0] block_le;  // bytes reversed per lane

  assign block = {job.header, job.nonce, pad_tail};

  // the header arrives big endian, keccak lanes are little endian
  always_comb
  begin
    for (int w = 0; w < rate_lanes; w++)
    begin
      for (int b = 0; b < lane_bytes; b++)
      begin
        block_le[w*lane_w + b*8 +: 8] = block[w*lane_w + (lane_bytes - 1 - b)*8 +: 8];
      end
    end
  end

  // capacity lanes start at zero
  assign state = {block_le, {(state_w - rate_w){1'b0}}};

endmodule

// File: hdl/keccak_last_round.sv
`timescale 1ns/1ps

module keccak_last_round
  import keccak_pkg::*;
(
  input  logic   clk,
  input  state_t state_in,
  output lane_t  lane_out
);

  lane_t [0:4] col_par;
  lane_t       mix_0;
  lane_t       mix_3;
  lane_t       mix_4;
  lane_t       lane_00;  // (0,0) after theta and rho
  lane_t       lane_33;
  lane_t       lane_44;
  lane_t       lane_00_q;
  lane_t       lane_33_q;
  lane_t       lane_44_q;

  // all five parities are still needed for three columns
  always_comb
  begin
    for (int x = 0; x < 5; x++)
    begin
      col_par[x] = '0;
      for (int y = 0; y < 5; y++)
      begin
        col_par[x] = col_par[x] ^ state_in[lane_idx(x, y)];
      end
    end
  end

  assign mix_0 = col_par[4] ^ rotl(col_par[1], 1);
  assign mix_3 = col_par[2] ^ rotl(col_par[4], 1);
  assign mix_4 = col_par[3] ^ rotl(col_par[0], 1);

  assign lane_00 = rotl(state_in[lane_idx(0, 0)] ^ mix_0, rho_offsets[lane_idx(0, 0)]);
  assign lane_33 = rotl(state_in[lane_idx(3, 3)] ^ mix_3, rho_offsets[lane_idx(3, 3)]);
  assign lane_44 = rotl(state_in[lane_idx(4, 4)] ^ mix_4, rho_offsets[lane_idx(4, 4)]);

  always_ff @(posedge clk)
  begin
    lane_00_q <= lane_00;
    lane_33_q <= lane_33;
    lane_44_q <= lane_44;
  end

  // pi puts these three at x = 0, 3, 4 of row 0; chi for x = 3
  assign lane_out = lane_33_q ^ (~lane_44_q & lane_00_q);

endmodule

// File: hdl/keccak_miner.sv
`timescale 1ns/1ps

module keccak_miner
  import keccak_pkg::*;
#(
  parameter int TARGET_W = 32
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                job_valid,
  input  job_t                job,
  input  logic [TARGET_W-1:0] target,
  output logic                result_valid,
  output lane_t               hash,
  output logic                match
);

  logic  lane_valid;
  lane_t lane;
  logic  hi_zero;  // bits above the target width clear
  logic  lo_ok;
  logic  hit;

  keccak_pipeline i_pipeline (
    .clk        (clk),
    .rst        (rst),
    .job_valid  (job_valid),
    .job        (job),
    .lane_valid (lane_valid),
    .lane       (lane)
  );

  // shift is the whole lane when TARGET_W is 64, so always true then
  assign hi_zero = (lane >> TARGET_W) == '0;
  assign lo_ok   = lane[TARGET_W-1:0] <= target;
  assign hit     = hi_zero && lo_ok;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      result_valid <= 1'b0;
      match        <= 1'b0;
    end
    else
    begin
      result_valid <= lane_valid;
      match        <= lane_valid && hit;  // target taken at this edge
    end
  end

  always_ff @(posedge clk)
  begin
    hash <= lane;
  end

endmodule

// File: hdl/keccak_pipeline.sv
`timescale 1ns/1ps

module keccak_pipeline
  import keccak_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  job_valid,
  input  job_t  job,
  output logic  lane_valid,
  output lane_t lane
);

  localparam int full_rounds = num_rounds - 1;  // last one is truncated

  state_t                  absorbed;
  state_t                  round_out [full_rounds];
  state_t                  round_q   [full_rounds];  // between rounds
  logic [pipe_latency-2:0] valid_sr;

  keccak_absorb i_absorb (
    .job   (job),
    .state (absorbed)
  );

  for (genvar r = 0; r < full_rounds; r++)
  begin : g_round
    state_t round_in;

    if (r == 0)
    begin : g_first
      assign round_in = absorbed;
    end
    else
    begin : g_next
      assign round_in = round_q[r-1];
    end

    keccak_round #(
      .ROUND_IDX (r)
    ) i_round (
      .clk       (clk),
      .state_in  (round_in),
      .state_out (round_out[r])
    );
  end

  always_ff @(posedge clk)
  begin
    for (int r = 0; r < full_rounds; r++)
    begin
      round_q[r] <= round_out[r];
    end
  end

  keccak_last_round i_last (
    .clk      (clk),
    .state_in (round_q[full_rounds-1]),
    .lane_out (lane)
  );

  // one bit per register stage up to the last round output
  always_ff @(posedge clk)
  begin
    if (rst)
      valid_sr <= '0;
    else
      valid_sr <= {valid_sr[pipe_latency-3:0], job_valid};
  end

  assign lane_valid = valid_sr[pipe_latency-2];

endmodule

// File: hdl/keccak_pkg.sv
package keccak_pkg;

  localparam int lane_w       = 64;
  localparam int num_lanes    = 25;
  localparam int state_w      = lane_w * num_lanes;
  localparam int rate_w       = 1088;
  localparam int header_w     = 608;
  localparam int nonce_w      = 32;
  localparam int pad_w        = rate_w - header_w - nonce_w;
  localparam int num_rounds   = 24;
  localparam int pipe_latency = 2 * (num_rounds - 1) + 2;  // 48

  typedef logic [lane_w-1:0] lane_t;

  // lane (x,y) sits at index x + 5*y, lane 0 in the top bits
  typedef lane_t [0:num_lanes-1] state_t;

  typedef logic [header_w-1:0] header_t;
  typedef logic [nonce_w-1:0]  nonce_t;

  typedef struct packed {
    header_t header;
    nonce_t  nonce;
  } job_t;

  // keccak pad10*1 for a single block, 0x01 domain byte
  localparam logic [pad_w-1:0] pad_tail = {8'h01, {(pad_w - 16){1'b0}}, 8'h80};

  // iota constants, 7 bits each, see expand_rc
  localparam logic [0:num_rounds-1][6:0] round_consts = {
    7'b0000001, 7'b0011010, 7'b1011110, 7'b1110000,
    7'b0011111, 7'b0100001, 7'b1111001, 7'b1010101,
    7'b0001110, 7'b0001100, 7'b0110101, 7'b0100110,
    7'b0111111, 7'b1001111, 7'b1011101, 7'b1010011,
    7'b1010010, 7'b1001000, 7'b0010110, 7'b1100110,
    7'b1111001, 7'b1011000, 7'b0100001, 7'b1110100
  };

  // rho rotations, one row per y
  localparam logic [0:num_lanes-1][5:0] rho_offsets = {
    6'd0,  6'd1,  6'd62, 6'd28, 6'd27,
    6'd36, 6'd44, 6'd6,  6'd55, 6'd20,
    6'd3,  6'd10, 6'd43, 6'd25, 6'd39,
    6'd41, 6'd45, 6'd15, 6'd21, 6'd8,
    6'd18, 6'd2,  6'd61, 6'd56, 6'd14
  };

  function automatic int unsigned lane_idx(int unsigned x, int unsigned y);
    return x + 5 * y;
  endfunction

  // rotate left, n = 0 leaves the lane unchanged
  function automatic lane_t rotl(lane_t v, int unsigned n);
    return (v << n) | (v >> (lane_w - n));
  endfunction

  // bit j of the short form lands on lane bit 2^j - 1
  function automatic lane_t expand_rc(logic [6:0] rc);
    lane_t full;
    full = '0;
    for (int j = 0; j < 7; j++)
    begin
      full[(1 << j) - 1] = rc[j];
    end
    return full;
  endfunction

endpackage

// File: hdl/keccak_round.sv
`timescale 1ns/1ps

module keccak_round
  import keccak_pkg::*;
#(
  parameter int ROUND_IDX = 0
) (
  input  logic   clk,
  input  state_t state_in,
  output state_t state_out
);

  localparam lane_t iota_rc = expand_rc(round_consts[ROUND_IDX]);

  lane_t [0:4] col_par;  // theta column parities
  lane_t [0:4] col_mix;  // value folded into each column
  state_t      rho_out;
  state_t      rho_q;    // mid-round register
  state_t      pi_out;
  state_t      chi_out;

  // theta then rho
  always_comb
  begin
    for (int x = 0; x < 5; x++)
    begin
      col_par[x] = '0;
      for (int y = 0; y < 5; y++)
      begin
        col_par[x] = col_par[x] ^ state_in[lane_idx(x, y)];
      end
    end

    for (int x = 0; x < 5; x++)
    begin
      col_mix[x] = col_par[(x + 4) % 5] ^ rotl(col_par[(x + 1) % 5], 1);
    end

    for (int y = 0; y < 5; y++)
    begin
      for (int x = 0; x < 5; x++)
      begin
        rho_out[lane_idx(x, y)] = rotl(state_in[lane_idx(x, y)] ^ col_mix[x],
                                       rho_offsets[lane_idx(x, y)]);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    rho_q <= rho_out;
  end

  // pi moves lane (x,y) to (y, 2x+3y)
  always_comb
  begin
    for (int y = 0; y < 5; y++)
    begin
      for (int x = 0; x < 5; x++)
      begin
        pi_out[lane_idx(y, (2 * x + 3 * y) % 5)] = rho_q[lane_idx(x, y)];
      end
    end
  end

  // chi works along each row
  always_comb
  begin
    for (int y = 0; y < 5; y++)
    begin
      for (int x = 0; x < 5; x++)
      begin
        chi_out[lane_idx(x, y)] = pi_out[lane_idx(x, y)]
                                ^ (~pi_out[lane_idx((x + 1) % 5, y)]
                                   & pi_out[lane_idx((x + 2) % 5, y)]);
      end
    end
  end

  // iota only touches lane (0,0)
  always_comb
  begin
    state_out    = chi_out;
    state_out[0] = chi_out[0] ^ iota_rc;
  end

endmodule

// File: tests/keccak_miner_props.sv
`timescale 1ns/1ps

module keccak_miner_props
  import keccak_pkg::*;
(
  input logic clk,
  input logic rst,
  input logic job_valid,
  input logic result_valid,
  input logic match
);

  // fixed latency, no stalls
  a_latency: assert property (@(posedge clk) disable iff (rst)
    job_valid |-> ##pipe_latency result_valid)
    else $error("result_valid missing pipe_latency cycles after job_valid");

  a_match_valid: assert property (@(posedge clk) match |-> result_valid)
    else $error("match high while result_valid is low");

  a_reset_clear: assert property (@(posedge clk) rst |=> !result_valid && !match)
    else $error("result_valid or match high in the cycle after rst");

endmodule

bind keccak_miner keccak_miner_props i_props (
  .clk          (clk),
  .rst          (rst),
  .job_valid    (job_valid),
  .result_valid (result_valid),
  .match        (match)
);

// File: tests/keccak_model.svh
`ifndef KECCAK_MODEL_SVH
`define KECCAK_MODEL_SVH

// reference keccak-f[1600], lane (x,y) kept at a[x + 5*y]

function automatic lane_t rol64(lane_t v, int n);
  int s;
  s = n % 64;
  if (s == 0)
    return v;
  return (v << s) | (v >> (64 - s));
endfunction

// the seven table bits land on lane bits 0, 1, 3, 7, 15, 31, 63
function automatic lane_t full_rc(int rnd);
  int    pos [7] = '{0, 1, 3, 7, 15, 31, 63};
  lane_t rc;
  rc = '0;
  for (int j = 0; j < 7; j++)
    rc[pos[j]] = round_consts[rnd][j];
  return rc;
endfunction

function automatic lane_t expected_hash(job_t j);
  logic [1087:0] msg;
  lane_t         a [25];
  lane_t         b [25];
  lane_t         c [5];
  lane_t         d [5];
  msg = {j.header, j.nonce, 8'h01, 432'd0, 8'h80};  // 80 bytes padded to 136
  for (int i = 0; i < 25; i++)
    a[i] = '0;
  // byte m of the message is byte m%8 of lane m/8, counted from the lsb
  for (int m = 0; m < 136; m++)
    a[m / 8][8 * (m % 8) +: 8] = msg[1087 - 8 * m -: 8];
  for (int r = 0; r < 24; r++)
  begin
    for (int x = 0; x < 5; x++)
      c[x] = a[x] ^ a[x + 5] ^ a[x + 10] ^ a[x + 15] ^ a[x + 20];
    for (int x = 0; x < 5; x++)
      d[x] = c[(x + 4) % 5] ^ rol64(c[(x + 1) % 5], 1);
    for (int i = 0; i < 25; i++)
      a[i] = a[i] ^ d[i % 5];
    for (int x = 0; x < 5; x++)
      for (int y = 0; y < 5; y++)
        b[y + 5 * ((2 * x + 3 * y) % 5)] = rol64(a[x + 5 * y], rho_offsets[x + 5 * y]);
    for (int x = 0; x < 5; x++)
      for (int y = 0; y < 5; y++)
        a[x + 5 * y] = b[x + 5 * y] ^ (~b[(x + 1) % 5 + 5 * y] & b[(x + 2) % 5 + 5 * y]);
    a[0] = a[0] ^ full_rc(r);
  end
  return a[3];  // lane (3,0)
endfunction

`endif

// File: tests/tb_keccak_miner.sv
`timescale 1ns/1ps

module tb_keccak_miner
  import keccak_pkg::*;
();

  localparam int target_w    = 64;
  localparam int drain_limit = 2 * pipe_latency + 10;

  logic                clk;
  logic                rst;
  logic                job_valid;
  job_t                job;
  logic [target_w-1:0] target;
  logic                result_valid;
  lane_t               hash;
  logic                match;

  lane_t exp_q [$];  // expected hashes, issue order
  int    due_q [$];  // negedge count when each result shows up
  int    cyc;
  logic  rst_seen;
  lane_t head_hash;
  int    head_due;
  int    hash_errors;
  int    match_errors;
  int    flow_errors;

  `include "keccak_model.svh"

  keccak_miner #(
    .TARGET_W (target_w)
  ) i_dut (
    .clk          (clk),
    .rst          (rst),
    .job_valid    (job_valid),
    .job          (job),
    .target       (target),
    .result_valid (result_valid),
    .hash         (hash),
    .match        (match)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic job_t random_job();
    job_t j;
    for (int w = 0; w < header_w / 32; w++)
      j.header[32 * w +: 32] = $urandom();
    j.nonce = $urandom();
    return j;
  endfunction

  task automatic send_job(input job_t j);
    @(posedge clk);
    #1;
    job_valid = 1'b1;
    job       = j;
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
      job_valid = 1'b0;
    end
  endtask

  // only called with the pipeline empty
  task automatic set_target(input lane_t t);
    idle(1);
    target = t;
  endtask

  task automatic drain();
    int n;
    n = 0;
    idle(1);
    while (exp_q.size() != 0 && n < drain_limit)
    begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0)
    begin
      $display("timeout: %0d results never arrived", exp_q.size());
      flow_errors++;
      exp_q.delete();
      due_q.delete();
    end
  endtask

  // outputs are stable half a period after the edge
  always @(negedge clk)
  begin
    cyc = cyc + 1;
    if (rst_seen)
      assert (result_valid === 1'b0 && match === 1'b0)
      else
      begin
        flow_errors++;
        $display("result_valid or match still high after reset at %0t", $time);
      end
    assert (match !== 1'b1 || result_valid === 1'b1)
    else
    begin
      flow_errors++;
      $display("match high without result_valid at %0t", $time);
    end
    if (result_valid === 1'b1 && exp_q.size() == 0)
    begin
      flow_errors++;
      $display("result_valid with no job in flight at %0t", $time);
    end
    else if (result_valid === 1'b1)
    begin
      head_hash = exp_q.pop_front();
      head_due  = due_q.pop_front();
      assert (head_due == cyc)
      else
      begin
        flow_errors++;
        $display("[ERROR] %0t result_valid cycle expected %0d actual %0d", $time, head_due, cyc);
      end
      assert (hash === head_hash)
      else
      begin
        hash_errors++;
        $display("[ERROR] %0t hash expected %h actual %h", $time, head_hash, hash);
      end
      // full-width target, so only the compare is left of the rule
      assert (match === (head_hash <= target))
      else
      begin
        match_errors++;
        $display("[ERROR] %0t match expected %b actual %b", $time, head_hash <= target, match);
      end
    end
    else if (due_q.size() != 0 && due_q[0] <= cyc)
    begin
      flow_errors++;
      $display("result_valid missing at %0t", $time);
      void'(exp_q.pop_front());
      void'(due_q.pop_front());
    end
    rst_seen = rst;
    if (rst)
    begin
      exp_q.delete();  // jobs in flight are dropped
      due_q.delete();
    end
    else if (job_valid)
    begin
      exp_q.push_back(expected_hash(job));
      due_q.push_back(cyc + pipe_latency);
    end
  end

  initial
  begin
    job_t  pj;
    lane_t ph;
    void'($urandom(32'h25cc_3fd6));
    rst          = 1'b1;
    job_valid    = 1'b0;
    job          = '0;
    target       = '1;
    cyc          = 0;
    rst_seen     = 1'b0;
    hash_errors  = 0;
    match_errors = 0;
    flow_errors  = 0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    idle(2 * pipe_latency);  // nothing issued yet
    send_job(random_job());
    drain();

    // random gaps, then a burst long enough to fill the pipe
    for (int i = 0; i < 120; i++)
    begin
      if ($urandom_range(0, 2) != 0)
        send_job(random_job());
      else
        idle(1);
    end
    for (int i = 0; i < 70; i++)
      send_job(random_job());
    drain();

    set_target('0);
    for (int i = 0; i < 6; i++)
      send_job(random_job());
    drain();

    pj = random_job();
    ph = expected_hash(pj);
    set_target(ph);
    send_job(pj);
    drain();
    set_target(ph - 1);
    send_job(pj);
    drain();

    set_target('1);
    // results already streaming out when reset hits
    for (int i = 0; i < pipe_latency + 12; i++)
      send_job(random_job());
    idle(1);
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    idle(pipe_latency + 10);  // dropped jobs must not come out
    send_job(random_job());
    drain();
    idle(5);

    $display("errors: hash %0d, match %0d, flow %0d", hash_errors, match_errors, flow_errors);
    if (hash_errors + match_errors + flow_errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule
